// File: files.f
cpu_types_pkg.sv
pipe_ctrl_pkg.sv
register_file.sv
fetch_stage.sv
decode_stage.sv
exec_stage.sv
hazard_forward_unit.sv
memwb_stage.sv
pipeline_core.sv
tb_clock_gen.sv
tb_core_assert.sv
tb_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_core \
  -Mdir obj_dir -o sim_core > build.log 2>&1 \
  && ./obj_dir/sim_core > sim.log 2>&1
grep -q "Simulation PASSED" sim.log && echo "run passed" || { echo "run failed, see sim.log"; exit 1; }

// File: tb_core.sv
module tb_core import cpu_types_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam word_t PC_INIT  = 32'h0000_0100;
  localparam int    MAX_WAIT = 3;
  localparam int    ALU_LEN  = 19;
  localparam int    LOAD_LEN = 8;
  localparam int    CTRL_LEN = 14;
  localparam int    HALT_LEN = 5;
  // every program runs twice except the halt one, plus reset and drain per run
  localparam int    WATCHDOG_CYCLES =
    (2 * (ALU_LEN + LOAD_LEN + CTRL_LEN) + HALT_LEN) * (MAX_WAIT + 1) * 3 + 8 * 60;

  logic  CLK, nRST;
  logic  imem_ren, dmem_ren, dmem_wen, halt, ihit, dhit;
  word_t imem_addr, imem_load, dmem_addr, dmem_store, dmem_load;

  word_t  imem [256];
  word_t  dmem [256];
  word_t  prog [$];
  word_t  exp_addr [$], exp_data [$], got_addr [$], got_data [$];
  integer seed = 32'hf564_ca59;
  int     max_wait, errors, icnt, icur, iwait, dcnt, dcur, dwait;
  word_t  iaddr_q, daddr_q;

  tb_clock_gen #(.PERIOD(8ns)) u_clk (.CLK(CLK));

  pipeline_core #(.PC_INIT(PC_INIT)) u_dut (.*);

  // ------------------------------------------------
  // memory models, wait counted per held address
  assign icur      = (imem_addr == iaddr_q) ? icnt : 0;
  assign ihit      = imem_ren && (icur >= iwait);
  assign imem_load = imem[imem_addr[9:2]];
  assign dcur      = (dmem_addr == daddr_q) ? dcnt : 0;
  assign dhit      = (dmem_ren || dmem_wen) && (dcur >= dwait);
  assign dmem_load = dmem[dmem_addr[9:2]];

  function automatic int draw_wait();
    if (max_wait == 0) return 0;
    return int'($unsigned($random(seed)) % (max_wait + 1));
  endfunction

  always @(posedge CLK) begin
    iaddr_q <= imem_addr;
    icnt    <= ihit ? 0 : icur + 1;
    if (ihit) iwait <= draw_wait();
    daddr_q <= dmem_addr;
    dcnt    <= dhit ? 0 : dcur + 1;
    if (dhit) dwait <= draw_wait();
    if (dhit && dmem_wen) begin
      dmem[dmem_addr[9:2]] <= dmem_store;
      got_addr.push_back(dmem_addr);  // every store in order
      got_data.push_back(dmem_store);
    end
  end

  // ------------------------------------------------
  // instruction encoding
  function automatic word_t rtype_word(funct_t fn, regbits_t rs, regbits_t rt, regbits_t rd);
    return {RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t itype_word(opcode_t op, regbits_t rs, regbits_t rt,
                                       logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jump_word(word_t addr);
    return {J, addr[27:2]};
  endfunction

  function automatic word_t fill_value(word_t addr);
    return addr ^ 32'ha5a5_0000;  // unique per address
  endfunction

  // ------------------------------------------------
  // checks
  task automatic compare_word(string name, word_t expected, word_t actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic compare_flag(string name, logic expected, logic actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %b actual %b", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_test(string name, int errs_before);
    $display("test %-14s %s", name, (errors == errs_before) ? "ok" : "failed");
  endtask

  task automatic reset_core();
    @(posedge CLK);
    nRST <= 1'b0;
    repeat (10) @(posedge CLK);
    nRST <= 1'b1;
  endtask

  task automatic load_program();
    int base;
    base = int'(PC_INIT[9:2]);  // program sits at the reset address
    for (int i = 0; i < 256; i++) begin
      imem[i] = {HALT, 26'd0};
      dmem[i] = fill_value(word_t'(i * 4));
    end
    foreach (prog[i]) imem[base + i] = prog[i];
  endtask

  task automatic run_and_check(string name);
    int errs_before;
    errs_before = errors;
    load_program();
    reset_core();
    got_addr.delete();
    got_data.delete();
    @(posedge CLK);
    while (!halt) @(posedge CLK);
    repeat (4) @(posedge CLK);  // late stores would show up here
    if (got_addr.size() != exp_addr.size()) begin
      $display("ERROR %s store count expected %0d actual %0d",
               name, exp_addr.size(), got_addr.size());
      errors++;
    end else begin
      foreach (exp_addr[i]) begin
        compare_word({name, "_addr"}, exp_addr[i], got_addr[i]);
        compare_word({name, "_data"}, exp_data[i], got_data[i]);
      end
    end
    report_test(name, errs_before);
  endtask

  task automatic expect_store(word_t addr, word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // ------------------------------------------------
  // tests
  task automatic test_reset();
    int errs_before;
    errs_before = errors;
    @(posedge CLK);
    nRST <= 1'b0;
    repeat (3) @(posedge CLK);
    compare_flag("reset_halt", 1'b0, halt);
    compare_flag("reset_dmem_ren", 1'b0, dmem_ren);
    compare_flag("reset_dmem_wen", 1'b0, dmem_wen);
    compare_flag("reset_imem_ren", 1'b1, imem_ren);
    compare_word("reset_imem_addr", PC_INIT, imem_addr);
    report_test("reset", errs_before);
  endtask

  task automatic test_alu(string name);
    prog = '{itype_word(ADDIU, 0, 1, 16'd5), itype_word(ADDIU, 0, 2, 16'd7),
             rtype_word(ADDU, 1, 2, 3), rtype_word(SUBU, 3, 1, 4),
             rtype_word(AND, 3, 4, 5), rtype_word(OR, 5, 3, 6),
             rtype_word(SLT, 1, 3, 7), itype_word(LUI, 0, 8, 16'h1234),
             itype_word(ORI, 8, 8, 16'h5678), itype_word(ADDIU, 0, 9, 16'hffff),
             rtype_word(SLT, 9, 1, 10), itype_word(SW, 0, 10, 16'd24),
             itype_word(SW, 0, 3, 16'd0), itype_word(SW, 0, 4, 16'd4),
             itype_word(SW, 0, 5, 16'd8), itype_word(SW, 0, 6, 16'd12),
             itype_word(SW, 0, 7, 16'd16), itype_word(SW, 0, 8, 16'd20), {HALT, 26'd0}};
    exp_addr.delete();
    exp_data.delete();
    expect_store(32'd24, 32'd1);       // -1 < 5 signed
    expect_store(32'd0, 32'd5 + 32'd7);
    expect_store(32'd4, 32'd12 - 32'd5);
    expect_store(32'd8, 32'd12 & 32'd7);
    expect_store(32'd12, 32'd4 | 32'd12);
    expect_store(32'd16, 32'd1);
    expect_store(32'd20, 32'h1234_5678);
    run_and_check(name);
  endtask

  task automatic test_load_use(string name);
    word_t sum;
    sum  = fill_value(32'h40) + fill_value(32'h44);
    prog = '{itype_word(ADDIU, 0, 1, 16'h40), itype_word(LW, 1, 2, 16'd0),
             itype_word(LW, 1, 3, 16'd4), rtype_word(ADDU, 2, 3, 4),
             itype_word(SW, 1, 4, 16'd8), itype_word(LW, 1, 5, 16'd8),
             itype_word(SW, 1, 5, 16'd12), {HALT, 26'd0}};
    exp_addr.delete();
    exp_data.delete();
    expect_store(32'h48, sum);
    expect_store(32'h4c, sum);  // reload of the stored sum
    run_and_check(name);
  endtask

  task automatic test_control(string name);
    prog = '{itype_word(ADDIU, 0, 1, 16'd3), itype_word(ADDIU, 0, 2, 16'd3),
             itype_word(BEQ, 1, 2, 16'd2),                                // to offset 20
             itype_word(SW, 0, 1, 16'd0), itype_word(SW, 0, 2, 16'd4),   // shadow
             itype_word(SW, 0, 1, 16'd8), itype_word(ADDIU, 0, 3, 16'd9),
             itype_word(BEQ, 1, 3, 16'd1),                                // falls through
             itype_word(SW, 0, 3, 16'd12), jump_word(PC_INIT + 32'd48),
             itype_word(SW, 0, 3, 16'd16), itype_word(SW, 0, 3, 16'd20), // shadow
             itype_word(SW, 0, 2, 16'd24), {HALT, 26'd0}};
    exp_addr.delete();
    exp_data.delete();
    expect_store(32'd8, 32'd3);
    expect_store(32'd12, 32'd9);
    expect_store(32'd24, 32'd3);
    run_and_check(name);
  endtask

  task automatic test_halt();
    int errs_before;
    errs_before = errors;
    prog = '{itype_word(ADDIU, 0, 1, 16'h2a), itype_word(SW, 0, 1, 16'd0), {HALT, 26'd0},
             itype_word(SW, 0, 1, 16'd4), itype_word(SW, 0, 1, 16'd8)};  // past halt
    load_program();
    reset_core();
    got_addr.delete();
    got_data.delete();
    @(posedge CLK);
    while (!halt) @(posedge CLK);
    repeat (8) begin
      @(posedge CLK);
      compare_flag("halt_hold", 1'b1, halt);
      compare_flag("halt_imem_ren", 1'b0, imem_ren);
      compare_flag("halt_dmem_wen", 1'b0, dmem_wen);
    end
    if (got_addr.size() != 1) begin
      $display("ERROR halt store count expected 1 actual %0d", got_addr.size());
      errors++;
    end else begin
      compare_word("halt_store_addr", 32'd0, got_addr[0]);
      compare_word("halt_store", 32'h2a, got_data[0]);
    end
    report_test("halt", errs_before);
  endtask

  // ------------------------------------------------
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("watchdog expired, the core never reached halt");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    nRST     = 1'b0;
    errors   = 0;
    max_wait = 0;
    icnt     = 0;
    iwait    = 0;
    dcnt     = 0;
    dwait    = 0;
    iaddr_q  = '0;
    daddr_q  = '0;
    load_program();
    test_reset();
    test_alu("alu");
    test_load_use("load_use");
    test_control("control");
    max_wait = MAX_WAIT;  // same programs, random hit delays
    test_alu("alu_waits");
    test_load_use("load_waits");
    test_control("control_waits");
    max_wait = 0;
    test_halt();
    $display("%0d tests run, %0d errors", 8, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: tb_core_assert.sv
module tb_core_assert import cpu_types_pkg::*; (
  input logic  CLK,
  input logic  nRST,
  input logic  halt,
  input logic  imem_ren,
  input logic  dmem_ren,
  input logic  dmem_wen,
  input logic  dhit,
  input word_t dmem_addr,
  input word_t dmem_store
);
  timeunit 1ns;
  timeprecision 100ps;

  a_one_request: assert property (@(posedge CLK) disable iff (!nRST)
    !(dmem_ren && dmem_wen)) else $error("data read and write requested together");

  a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt) else $error("halt dropped before reset");

  a_no_fetch: assert property (@(posedge CLK) disable iff (!nRST)
    halt |-> !imem_ren) else $error("fetch request while halted");

  // request must hold until the hit strobe
  a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
    ((dmem_ren || dmem_wen) && !dhit) |=> ($stable(dmem_addr) && $stable(dmem_store)))
    else $error("data request changed while waiting");

endmodule

bind pipeline_core tb_core_assert u_assert (.*);

// File: tb_clock_gen.sv
module tb_clock_gen #(
  parameter realtime PERIOD = 8ns
) (
  output logic CLK
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;  // free running
  end

endmodule

// File: pipeline_core.sv
module pipeline_core import cpu_types_pkg::*; import pipe_ctrl_pkg::*; #(
  parameter word_t PC_INIT = '0
) (
  input  logic  CLK,
  input  logic  nRST,
  // instruction memory
  output logic  imem_ren,
  output word_t imem_addr,
  input  word_t imem_load,
  input  logic  ihit,
  // data memory
  output logic  dmem_ren,
  output logic  dmem_wen,
  output word_t dmem_addr,
  output word_t dmem_store,
  input  word_t dmem_load,
  input  logic  dhit,
  output logic  halt
);

  // hazard control
  logic     stall_fd, flush_fd, flush_de, freeze, mem_wait;
  fwd_sel_t fwd_a, fwd_b;

  // fetch -> decode
  word_t    instr, pc_plus4;

  // decode -> execute
  regbits_t dec_rs, dec_rt, de_rs, de_rt, de_dest;
  word_t    de_rdat1, de_rdat2, de_imm, de_jtarget, de_pc_plus4;
  aluop_t   de_aluop;
  logic     de_alu_src, de_reg_wr, de_mem_rd, de_mem_wr, de_beq, de_jmp, de_halt;

  // execute -> memory, and redirect back to fetch
  logic     taken, ex_mem_rd;
  word_t    target, em_alu, em_store;
  regbits_t ex_dest, em_dest;
  logic     em_reg_wr, em_mem_rd, em_mem_wr, em_halt;

  // memory/writeback -> decode and forwarding
  word_t    mem_result, wb_data;
  regbits_t mem_dest, wb_sel_reg, wb_dest;
  logic     mem_reg_wr, wb_en;

  fetch_stage #(.PC_INIT(PC_INIT)) u_fetch (.*);

  decode_stage u_decode (.*);

  exec_stage u_exec (.*);

  hazard_forward_unit u_hazard (
    .wb_reg_wr (wb_en),
    .*
  );

  memwb_stage u_memwb (.*);

endmodule

// File: memwb_stage.sv
module memwb_stage import cpu_types_pkg::*; import pipe_ctrl_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  word_t    em_alu,
  input  word_t    em_store,
  input  regbits_t em_dest,
  input  logic     em_reg_wr,
  input  logic     em_mem_rd,
  input  logic     em_mem_wr,
  input  logic     em_halt,
  input  logic     dhit,
  input  word_t    dmem_load,
  output logic     dmem_ren,
  output logic     dmem_wen,
  output word_t    dmem_addr,
  output word_t    dmem_store,
  output logic     mem_wait,
  output word_t    mem_result,
  output regbits_t mem_dest,
  output logic     mem_reg_wr,
  output logic     wb_en,
  output regbits_t wb_sel_reg,
  output word_t    wb_data,
  output regbits_t wb_dest,
  output logic     halt
);

  wb_sel_t  wb_sel;
  word_t    wb_alu, wb_load;
  regbits_t wb_wsel;
  logic     wb_halt;

  // request held until the hit strobe
  assign dmem_ren   = em_mem_rd;
  assign dmem_wen   = em_mem_wr;
  assign dmem_addr  = em_alu;
  assign dmem_store = em_store;
  assign mem_wait   = (em_mem_rd | em_mem_wr) & ~dhit;

  assign mem_result = em_alu;
  assign mem_dest   = em_dest;
  assign mem_reg_wr = em_reg_wr;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      wb_en   <= 1'b0;
      wb_sel  <= WB_ALU;
      wb_halt <= 1'b0;
      halt    <= 1'b0;
    end else begin
      halt <= halt | wb_halt;  // sticky until reset
      if (!mem_wait) begin
        wb_en   <= em_reg_wr;
        wb_sel  <= em_mem_rd ? WB_MEM : WB_ALU;
        wb_halt <= em_halt;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!mem_wait) begin
      wb_alu  <= em_alu;
      wb_load <= dmem_load;  // valid in the hit cycle
      wb_wsel <= em_dest;
    end
  end

  assign wb_data    = (wb_sel == WB_MEM) ? wb_load : wb_alu;
  assign wb_sel_reg = wb_wsel;
  assign wb_dest    = wb_wsel;

endmodule

// File: hazard_forward_unit.sv
module hazard_forward_unit import cpu_types_pkg::*; import pipe_ctrl_pkg::*; (
  input  regbits_t dec_rs,
  input  regbits_t dec_rt,
  input  regbits_t ex_dest,
  input  logic     ex_mem_rd,
  input  logic     taken,
  input  regbits_t mem_dest,
  input  logic     mem_reg_wr,
  input  regbits_t wb_dest,
  input  logic     wb_reg_wr,
  input  logic     mem_wait,
  input  logic     ihit,
  output logic     stall_fd,
  output logic     flush_fd,
  output logic     flush_de,
  output logic     freeze,
  output fwd_sel_t fwd_a,
  output fwd_sel_t fwd_b
);

  logic load_use;

  // select for the op in decode, taken up by execute on the next edge.
  // the op now in execute moves to memory, the memory op moves to writeback
  function automatic fwd_sel_t next_sel(regbits_t src);
    if (src == '0) begin
      return FWD_NONE;
    end else if (ex_dest == src) begin  // ex_dest is zero unless written
      return FWD_MEM;
    end else if (mem_reg_wr && (mem_dest == src)) begin
      return FWD_WB;
    end else if (wb_reg_wr && (wb_dest == src)) begin
      return FWD_NONE;  // register file bypass covers this one
    end
    return FWD_NONE;
  endfunction

  assign load_use = ex_mem_rd && (ex_dest != '0) &&
                    ((ex_dest == dec_rs) || (ex_dest == dec_rt));

  assign stall_fd = load_use;
  assign flush_de = taken | load_use;             // bubble into execute
  assign flush_fd = taken | (~ihit & ~load_use);  // no instruction this cycle
  assign freeze   = mem_wait;

  assign fwd_a = next_sel(dec_rs);
  assign fwd_b = next_sel(dec_rt);

endmodule

// File: exec_stage.sv
module exec_stage import cpu_types_pkg::*; import pipe_ctrl_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  word_t    de_rdat1,
  input  word_t    de_rdat2,
  input  word_t    de_imm,
  input  regbits_t de_rs,
  input  regbits_t de_rt,
  input  regbits_t de_dest,
  input  aluop_t   de_aluop,
  input  logic     de_alu_src,
  input  logic     de_reg_wr,
  input  logic     de_mem_rd,
  input  logic     de_mem_wr,
  input  logic     de_beq,
  input  logic     de_jmp,
  input  logic     de_halt,
  input  word_t    de_jtarget,
  input  word_t    de_pc_plus4,
  input  fwd_sel_t fwd_a,
  input  fwd_sel_t fwd_b,
  input  word_t    mem_result,
  input  word_t    wb_data,
  input  logic     freeze,
  output logic     taken,
  output word_t    target,
  output regbits_t ex_dest,
  output logic     ex_mem_rd,
  output word_t    em_alu,
  output word_t    em_store,
  output regbits_t em_dest,
  output logic     em_reg_wr,
  output logic     em_mem_rd,
  output logic     em_mem_wr,
  output logic     em_halt
);

  fwd_sel_t sel_a_q, sel_b_q;  // selects picked while this op sat in decode
  word_t    opa, rt_val, opb, alu_out;

  function automatic word_t pick(fwd_sel_t sel, word_t rf_val);
    case (sel)
      FWD_MEM: return mem_result;
      FWD_WB:  return wb_data;
      default: return rf_val;
    endcase
  endfunction

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      sel_a_q <= FWD_NONE;
      sel_b_q <= FWD_NONE;
    end else if (!freeze) begin
      sel_a_q <= fwd_a;
      sel_b_q <= fwd_b;
    end
  end

  always_comb begin
    opa    = pick((de_rs == '0) ? FWD_NONE : sel_a_q, de_rdat1);
    rt_val = pick((de_rt == '0) ? FWD_NONE : sel_b_q, de_rdat2);
    opb    = de_alu_src ? de_imm : rt_val;
    case (de_aluop)
      ALU_ADD: alu_out = opa + opb;
      ALU_SUB: alu_out = opa - opb;
      ALU_AND: alu_out = opa & opb;
      ALU_OR:  alu_out = opa | opb;
      ALU_SLT: alu_out = ($signed(opa) < $signed(opb)) ? 32'd1 : 32'd0;
      ALU_LUI: alu_out = {opb[15:0], 16'h0000};
      default: alu_out = '0;
    endcase
  end

  // branch / jump resolution
  assign taken  = de_jmp | (de_beq & (opa == rt_val));
  assign target = de_jmp ? de_jtarget : de_pc_plus4 + {de_imm[29:0], 2'b00};

  assign ex_dest   = de_reg_wr ? de_dest : '0;  // zero when nothing is written
  assign ex_mem_rd = de_mem_rd;

  // ------------------------------------------------
  // execute/memory register
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      em_reg_wr <= 1'b0;
      em_mem_rd <= 1'b0;
      em_mem_wr <= 1'b0;
      em_halt   <= 1'b0;
    end else if (!freeze) begin
      em_reg_wr <= de_reg_wr & ~em_halt;
      em_mem_rd <= de_mem_rd & ~em_halt;
      em_mem_wr <= de_mem_wr & ~em_halt;
      em_halt   <= em_halt | de_halt;  // younger ops dropped once halt passes
    end
  end

  always_ff @(posedge CLK) begin
    if (!freeze) begin
      em_alu   <= alu_out;
      em_store <= rt_val;
      em_dest  <= de_dest;
    end
  end

endmodule

// File: decode_stage.sv
module decode_stage import cpu_types_pkg::*; import pipe_ctrl_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  word_t    instr,
  input  word_t    pc_plus4,
  input  logic     flush_de,
  input  logic     freeze,
  input  logic     wb_en,
  input  regbits_t wb_sel_reg,
  input  word_t    wb_data,
  output regbits_t dec_rs,
  output regbits_t dec_rt,
  output word_t    de_rdat1,
  output word_t    de_rdat2,
  output word_t    de_imm,
  output regbits_t de_rs,
  output regbits_t de_rt,
  output regbits_t de_dest,
  output aluop_t   de_aluop,
  output logic     de_alu_src,
  output logic     de_reg_wr,
  output logic     de_mem_rd,
  output logic     de_mem_wr,
  output logic     de_beq,
  output logic     de_jmp,
  output logic     de_halt,
  output word_t    de_jtarget,
  output word_t    de_pc_plus4
);

  opcode_t op;
  funct_t  fn;
  word_t   rdat1;
  word_t   rdat2;
  word_t   ext_imm;
  aluop_t  aluop;
  wb_sel_t wb_src;
  logic    alu_src, reg_wr, mem_wr, beq, jmp, halt_flag;
  logic    use_rd, zero_ext;

  assign op     = opcode_t'(instr[31:26]);
  assign fn     = funct_t'(instr[5:0]);
  assign dec_rs = instr[25:21];
  assign dec_rt = instr[20:16];

  assign ext_imm = zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

  register_file u_rf (
    .CLK   (CLK),
    .nRST  (nRST),
    .rsel1 (dec_rs),
    .rsel2 (dec_rt),
    .wen   (wb_en),
    .wsel  (wb_sel_reg),
    .wdat  (wb_data),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  // ------------------------------------------------
  // control decode
  always_comb begin
    aluop     = ALU_ADD;
    wb_src    = WB_ALU;
    alu_src   = 1'b0;
    reg_wr    = 1'b0;
    mem_wr    = 1'b0;
    beq       = 1'b0;
    jmp       = 1'b0;
    halt_flag = 1'b0;
    use_rd    = 1'b0;
    zero_ext  = 1'b0;
    case (op)
      RTYPE: begin
        use_rd = 1'b1;
        reg_wr = 1'b1;
        case (fn)
          ADDU:    aluop = ALU_ADD;
          SUBU:    aluop = ALU_SUB;
          AND:     aluop = ALU_AND;
          OR:      aluop = ALU_OR;
          SLT:     aluop = ALU_SLT;
          default: reg_wr = 1'b0;  // nop and anything unsupported
        endcase
      end
      ADDIU: begin
        alu_src = 1'b1;
        reg_wr  = 1'b1;
      end
      ORI, LUI: begin
        aluop    = (op == LUI) ? ALU_LUI : ALU_OR;
        alu_src  = 1'b1;
        reg_wr   = 1'b1;
        zero_ext = 1'b1;
      end
      LW: begin
        alu_src = 1'b1;
        reg_wr  = 1'b1;
        wb_src  = WB_MEM;
      end
      SW: begin
        alu_src = 1'b1;
        mem_wr  = 1'b1;
      end
      BEQ:     beq = 1'b1;  // compared in execute
      J:       jmp = 1'b1;
      HALT:    halt_flag = 1'b1;
      default: ;
    endcase
  end

  // decode/execute register, flags cleared on flush
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      de_reg_wr <= 1'b0;
      de_mem_rd <= 1'b0;
      de_mem_wr <= 1'b0;
      de_beq    <= 1'b0;
      de_jmp    <= 1'b0;
      de_halt   <= 1'b0;
    end else if (!freeze) begin
      de_reg_wr <= reg_wr & ~flush_de;
      de_mem_rd <= (wb_src == WB_MEM) & ~flush_de;
      de_mem_wr <= mem_wr & ~flush_de;
      de_beq    <= beq & ~flush_de;
      de_jmp    <= jmp & ~flush_de;
      de_halt   <= halt_flag & ~flush_de;
    end
  end

  always_ff @(posedge CLK) begin
    if (!freeze) begin
      de_rdat1    <= rdat1;
      de_rdat2    <= rdat2;
      de_imm      <= ext_imm;
      de_rs       <= dec_rs;
      de_rt       <= dec_rt;
      de_dest     <= use_rd ? instr[15:11] : dec_rt;
      de_aluop    <= aluop;
      de_alu_src  <= alu_src;
      de_jtarget  <= {pc_plus4[31:28], instr[25:0], 2'b00};
      de_pc_plus4 <= pc_plus4;
    end
  end

endmodule

// File: fetch_stage.sv
module fetch_stage import cpu_types_pkg::*; #(
  parameter word_t PC_INIT = '0
) (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  ihit,
  input  word_t imem_load,
  input  logic  stall_fd,
  input  logic  flush_fd,
  input  logic  freeze,
  input  logic  taken,
  input  word_t target,
  input  logic  halt,
  output logic  imem_ren,
  output word_t imem_addr,
  output word_t instr,
  output word_t pc_plus4
);

  word_t pc;
  word_t pc_next;
  word_t seq_pc;

  assign seq_pc    = pc + 32'd4;
  assign imem_ren  = ~halt;  // fetch stops for good once halted
  assign imem_addr = pc;

  always_comb begin
    pc_next = pc;
    if (taken) begin
      pc_next = target;  // redirect from execute wins
    end else if (ihit && !stall_fd) begin
      pc_next = seq_pc;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
    end else if (!freeze) begin
      pc <= pc_next;
    end
  end

  // fetch/decode register, all-zero word is the nop bubble
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      instr    <= '0;
      pc_plus4 <= '0;
    end else if (!freeze) begin
      if (flush_fd) begin
        instr <= '0;
      end else if (!stall_fd) begin
        instr    <= imem_load;
        pc_plus4 <= seq_pc;
      end
    end
  end

endmodule

// File: register_file.sv
module register_file import cpu_types_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  regbits_t rsel1,
  input  regbits_t rsel2,
  input  logic     wen,
  input  regbits_t wsel,
  input  word_t    wdat,
  output word_t    rdat1,
  output word_t    rdat2
);

  word_t regs [32];

  // same-cycle write shows up on the read port
  function automatic word_t read_port(regbits_t sel);
    if (sel == '0) begin
      return '0;
    end else if (wen && (sel == wsel)) begin
      return wdat;
    end
    return regs[sel];
  endfunction

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wen && (wsel != '0)) begin  // $0 stays zero
      regs[wsel] <= wdat;
    end
  end

  always_comb begin
    rdat1 = read_port(rsel1);
    rdat2 = read_port(rsel2);
  end

endmodule

// File: pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

  // where an execute operand comes from
  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,  // value read in decode
    FWD_MEM  = 2'b01,  // alu result sitting in memory stage
    FWD_WB   = 2'b10   // writeback data
  } fwd_sel_t;

  // writeback data source
  typedef enum logic {
    WB_ALU = 1'b0,
    WB_MEM = 1'b1
  } wb_sel_t;

endpackage

// File: cpu_types_pkg.sv
package cpu_types_pkg;

  parameter int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;  // data and address
  typedef logic [4:0]        regbits_t;

  // ------------------------------------------------
  // primary opcode, bits 31:26
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    BEQ   = 6'b000100,
    ADDIU = 6'b001001,
    ORI   = 6'b001101,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  // funct field of r-type, bits 5:0
  typedef enum logic [5:0] {
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    SLT  = 6'b101010
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4,  // signed compare
    ALU_LUI = 3'd5   // imm to upper half
  } aluop_t;

endpackage
